// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsCoreTb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: all.f
design/mipsPkg.sv
design/stageBus.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
dv/mipsCoreTb.sv

// File: design/decodeStage.sv
/* Instruction decode stage */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  wordT ifIdPcPlus4,
	input  wordT ifIdInstr,
	input  logic wbEn,
	input  regAddrT wbAddr,
	input  wordT wbData,
	idExBus.src idEx
);

	opcodeT opcode;
	wordT readData1;
	wordT readData2;
	wordT immExt;
	logic aluSrc, regDst, branch, memRead, memWrite, regWrite, memToReg;
	aluOpT aluOp;

	assign opcode = opcodeT'(ifIdInstr[31:26]);
	assign immExt = {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.readAddr1(ifIdInstr[25:21]),
		.readAddr2(ifIdInstr[20:16]),
		.readData1(readData1),
		.readData2(readData2),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	// Main control; anything unknown falls through as a no-op
	always_comb begin
		{aluSrc, regDst, branch, memRead, memWrite, regWrite, memToReg} = '0;
		aluOp = aluOpAdd;
		case (opcode)
			opRType: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				aluOp = aluOpFunct;
			end
			opLw: begin
				aluSrc = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			opSw: begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			opBeq: begin
				branch = 1'b1;
				aluOp = aluOpSub;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{idEx.aluSrc, idEx.regDst, idEx.branch, idEx.memRead} <= '0;
			{idEx.memWrite, idEx.regWrite, idEx.memToReg} <= '0;
			idEx.aluOp <= aluOpAdd;
		end else begin
			{idEx.aluSrc, idEx.regDst, idEx.branch, idEx.memRead} <=
				{aluSrc, regDst, branch, memRead};
			{idEx.memWrite, idEx.regWrite, idEx.memToReg} <= {memWrite, regWrite, memToReg};
			idEx.aluOp <= aluOp;
		end
	end

	always_ff @(posedge clk) begin
		idEx.pcPlus4 <= ifIdPcPlus4;
		idEx.readData1 <= readData1;
		idEx.readData2 <= readData2;
		idEx.immediate <= immExt;
		idEx.rt <= ifIdInstr[20:16];
		idEx.rd <= ifIdInstr[15:11];
	end

endmodule

`default_nettype wire

// File: design/executeStage.sv
/* Execute stage */
`timescale 1ns/1ps
`default_nettype none

module executeStage import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	idExBus.dst idEx,
	exMemBus.src exMem
);

	functT funct;
	aluCtrlT aluCtrl;
	wordT opB;
	wordT aluResult;
	wordT branchTarget;
	regAddrT destReg;

	// Funct sits in the low bits of the extended immediate
	assign funct = functT'(idEx.immediate[5:0]);

	always_comb begin
		case (idEx.aluOp)
			aluOpSub: aluCtrl = aluSub;
			aluOpFunct: begin
				case (funct)
					fnSub: aluCtrl = aluSub;
					fnAnd: aluCtrl = aluAnd;
					fnOr: aluCtrl = aluOr;
					fnSlt: aluCtrl = aluSlt;
					default: aluCtrl = aluAdd;
				endcase
			end
			default: aluCtrl = aluAdd;
		endcase
	end

	assign opB = idEx.aluSrc ? idEx.immediate : idEx.readData2;

	always_comb begin
		case (aluCtrl)
			aluAnd: aluResult = idEx.readData1 & opB;
			aluOr: aluResult = idEx.readData1 | opB;
			aluSub: aluResult = idEx.readData1 - opB;
			aluSlt: aluResult = {31'b0, $signed(idEx.readData1) < $signed(opB)};
			default: aluResult = idEx.readData1 + opB;
		endcase
	end

	assign branchTarget = idEx.pcPlus4 + {idEx.immediate[29:0], 2'b00};
	assign destReg = idEx.regDst ? idEx.rd : idEx.rt;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{exMem.branch, exMem.memRead, exMem.memWrite} <= '0;
			{exMem.regWrite, exMem.memToReg} <= '0;
		end else begin
			{exMem.branch, exMem.memRead, exMem.memWrite} <=
				{idEx.branch, idEx.memRead, idEx.memWrite};
			{exMem.regWrite, exMem.memToReg} <= {idEx.regWrite, idEx.memToReg};
		end
	end

	always_ff @(posedge clk) begin
		exMem.branchTarget <= branchTarget;
		exMem.zero <= (aluResult == '0);
		exMem.aluResult <= aluResult;
		exMem.storeData <= idEx.readData2;
		exMem.destReg <= destReg;
	end

	// Decoded control never asks for a load and a store at once
	noLoadStore: assert property (@(posedge clk) disable iff (!rstN)
		!(idEx.memRead && idEx.memWrite))
		else $error("memRead and memWrite both set in execute");

endmodule

`default_nettype wire

// File: design/fetchStage.sv
/* Instruction fetch stage */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import mipsPkg::*; #(
	parameter wordT resetPc = '0
) (
	input  logic clk,
	input  logic rstN,
	input  logic branchTaken,
	input  wordT branchTarget,
	input  wordT instr,
	output wordT instrAddr,
	output wordT ifIdPcPlus4,
	output wordT ifIdInstr
);

	wordT pc;
	wordT pcPlus4;

	assign pcPlus4 = pc + 32'd4;
	assign instrAddr = pc;

	// All-zero word decodes as a harmless R-type to r0
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			ifIdInstr <= '0;
		end else begin
			pc <= branchTaken ? branchTarget : pcPlus4;
			ifIdInstr <= instr;
		end
	end

	always_ff @(posedge clk) begin
		ifIdPcPlus4 <= pcPlus4;
	end

	// Branch targets from the memory stage must keep the PC aligned
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: design/memoryStage.sv
/* Memory and write-back stage */
`timescale 1ns/1ps
`default_nettype none

module memoryStage import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	exMemBus.dst exMem,
	output wordT memAddr,
	output wordT memWData,
	output logic memRead,
	output logic memWrite,
	input  wordT memRData,
	output logic branchTaken,
	output wordT branchTarget,
	output logic wbEn,
	output regAddrT wbAddr,
	output wordT wbData
);

	memWbBus memWb ();

	assign memAddr = exMem.aluResult;
	assign memWData = exMem.storeData;
	assign memRead = exMem.memRead;
	assign memWrite = exMem.memWrite;

	// beq resolves here and fetch redirects on the next edge
	assign branchTaken = exMem.branch & exMem.zero;
	assign branchTarget = exMem.branchTarget;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
		end
	end

	always_ff @(posedge clk) begin
		memWb.loadData <= memRData;
		memWb.aluResult <= exMem.aluResult;
		memWb.destReg <= exMem.destReg;
	end

	assign wbEn = memWb.regWrite;
	assign wbAddr = memWb.destReg;
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// File: design/mipsCore.sv
/* Five-stage MIPS core */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; #(
	parameter wordT resetPc = '0
) (
	input  logic clk,
	input  logic rstN,
	output wordT instrAddr,
	input  wordT instr,
	output wordT memAddr,
	output wordT memWData,
	output logic memRead,
	output logic memWrite,
	input  wordT memRData
);

	wordT ifIdPcPlus4;
	wordT ifIdInstr;
	logic branchTaken;
	wordT branchTarget;
	logic wbEn;
	regAddrT wbAddr;
	wordT wbData;

	idExBus idEx ();
	exMemBus exMem ();

	fetchStage #(.resetPc(resetPc)) fetch (
		.clk(clk),
		.rstN(rstN),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instr(instr),
		.instrAddr(instrAddr),
		.ifIdPcPlus4(ifIdPcPlus4),
		.ifIdInstr(ifIdInstr)
	);

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.ifIdPcPlus4(ifIdPcPlus4),
		.ifIdInstr(ifIdInstr),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.idEx(idEx.src)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx.dst),
		.exMem(exMem.src)
	);

	// Also closes the write-back loop into decode
	memoryStage memory (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem.dst),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRead(memRead),
		.memWrite(memWrite),
		.memRData(memRData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
/* MIPS pipeline shared types */
`default_nettype none

package mipsPkg;

	localparam int instrWidth = 32;
	localparam int regCount = 32;

	typedef logic [instrWidth-1:0] wordT;
	typedef logic [$clog2(regCount)-1:0] regAddrT;

	// Opcode field in bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type funct field in bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// Class handed from main control to ALU control
	typedef enum logic [1:0] {
		aluOpAdd   = 2'b00,
		aluOpSub   = 2'b01,
		aluOpFunct = 2'b10
	} aluOpT;

	typedef enum logic [3:0] {
		aluAnd = 4'b0000,
		aluOr  = 4'b0001,
		aluAdd = 4'b0010,
		aluSub = 4'b0110,
		aluSlt = 4'b0111
	} aluCtrlT;

endpackage

`default_nettype wire

// File: design/regFile.sv
/* Register file */
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  regAddrT readAddr1,
	input  regAddrT readAddr2,
	output wordT readData1,
	output wordT readData2,
	input  logic wbEn,
	input  regAddrT wbAddr,
	input  wordT wbData
);

	wordT regs [regCount];
	logic wbLive;

	// r0 is never written
	assign wbLive = wbEn && (wbAddr != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbLive) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Write-through so a reader two slots behind sees the new value
	assign readData1 = (readAddr1 == '0) ? '0 :
		(wbLive && wbAddr == readAddr1) ? wbData : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 :
		(wbLive && wbAddr == readAddr2) ? wbData : regs[readAddr2];

endmodule

`default_nettype wire

// File: design/stageBus.sv
/* Pipeline register buses */
`timescale 1ns/1ps
`default_nettype none

interface idExBus import mipsPkg::*; ();
	// Data
	wordT pcPlus4;
	wordT readData1;
	wordT readData2;
	wordT immediate;
	regAddrT rt;
	regAddrT rd;
	// Control grouped by consuming stage
	logic aluSrc;
	aluOpT aluOp;
	logic regDst;
	logic branch;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic memToReg;

	modport src (output pcPlus4, readData1, readData2, immediate, rt, rd,
		aluSrc, aluOp, regDst, branch, memRead, memWrite, regWrite, memToReg);
	modport dst (input pcPlus4, readData1, readData2, immediate, rt, rd,
		aluSrc, aluOp, regDst, branch, memRead, memWrite, regWrite, memToReg);
endinterface

interface exMemBus import mipsPkg::*; ();
	wordT branchTarget;
	logic zero;
	wordT aluResult;
	wordT storeData;
	regAddrT destReg;
	logic branch;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic memToReg;

	modport src (output branchTarget, zero, aluResult, storeData, destReg,
		branch, memRead, memWrite, regWrite, memToReg);
	modport dst (input branchTarget, zero, aluResult, storeData, destReg,
		branch, memRead, memWrite, regWrite, memToReg);
endinterface

interface memWbBus import mipsPkg::*; ();
	wordT loadData;
	wordT aluResult;
	regAddrT destReg;
	logic regWrite;
	logic memToReg;

	modport src (output loadData, aluResult, destReg, regWrite, memToReg);
	modport dst (input loadData, aluResult, destReg, regWrite, memToReg);
endinterface

`default_nettype wire

// File: dv/mipsCoreTb.sv
/* MIPS core testbench */
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

	localparam int clkPeriod = 100;
	localparam int resetCycles = 3;
	// Program, reset and drain with margin
	localparam int budgetCycles = 100;
	localparam int watchdogNs = 2 * budgetCycles * clkPeriod;
	localparam int drainCycles = 5;
	localparam int randomSeed = 94;
	localparam int romDepth = 64;
	localparam int ramDepth = 64;
	localparam wordT resetPc = 32'h0000_0040;

	logic clk = 1'b0;
	logic rstN;
	wordT instrAddr;
	wordT instr;
	wordT memAddr;
	wordT memWData;
	logic memRead;
	logic memWrite;
	wordT memRData;

	wordT rom [romDepth];
	wordT ram [ramDepth];
	wordT ramInit [ramDepth];
	logic brTaken [romDepth];
	wordT expAddr [64];
	wordT expData [64];
	int expCount = 0;
	int progCount = 0;
	int storeIdx = 0;
	int resetEdges = 0;
	int runEdges = 0;
	int errorCount = 0;
	int leftOver = 0;
	wordT endAddr;

	wordT romOffset;
	wordT beqTarget;
	wordT nextFetch;
	logic beqFetched;
	logic aroundReset;

	mipsCore #(.resetPc(resetPc)) DUT (
		.clk(clk),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRead(memRead),
		.memWrite(memWrite),
		.memRData(memRData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Instruction ROM answers in the same cycle
	assign romOffset = instrAddr - resetPc;
	assign instr = rom[romOffset[7:2]];
	assign memRData = ram[memAddr[7:2]];

	// Data RAM reloads its random image while reset is held
	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < ramDepth; i++) begin
				ram[6'(i)] <= ramInit[6'(i)];
			end
		end else if (memWrite) begin
			ram[memAddr[7:2]] <= memWData;
		end
	end

	always @(posedge clk) begin
		if (!rstN) begin
			resetEdges <= resetEdges + 1;
		end else begin
			runEdges <= runEdges + 1;
		end
		if (rstN && memWrite) begin
			storeIdx <= storeIdx + 1;
		end
	end

	// Where fetch must be four cycles after a beq
	assign beqFetched = rstN && (instr[31:26] == opBeq);
	assign beqTarget = instrAddr + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign nextFetch = brTaken[romOffset[7:2]] ? beqTarget : instrAddr + 32'd16;
	assign aroundReset = (!rstN && resetEdges > 0) || (rstN && runEdges == 0);

	task automatic flagError(input string msg);
		errorCount++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	function automatic wordT encodeR(input regAddrT rs, input regAddrT rt, input regAddrT rd,
		input functT fn);
		return {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic wordT encodeI(input logic [5:0] op, input regAddrT rs, input regAddrT rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input wordT w);
		rom[6'(progCount)] = w;
		progCount++;
	endtask

	// Dependent instructions sit at least two slots apart
	task automatic assembleProgram();
		for (int i = 0; i < romDepth; i++) begin
			rom[6'(i)] = '0;
			brTaken[6'(i)] = 1'b0;
		end
		emit('0);
		emit(encodeI(opLw, 5'd0, 5'd1, 16'h0000));
		emit(encodeI(opLw, 5'd0, 5'd2, 16'h0004));
		emit(encodeI(opLw, 5'd0, 5'd3, 16'h0008));
		emit(encodeI(opLw, 5'd0, 5'd4, 16'h000c));
		emit(encodeR(5'd1, 5'd2, 5'd5, fnAdd));
		emit(encodeR(5'd1, 5'd3, 5'd6, fnSub));
		emit(encodeR(5'd2, 5'd4, 5'd7, fnAnd));
		emit(encodeR(5'd3, 5'd4, 5'd8, fnOr));
		emit(encodeR(5'd1, 5'd2, 5'd9, fnSlt));
		emit(encodeI(opSw, 5'd0, 5'd5, 16'h0080));
		emit(encodeI(opSw, 5'd0, 5'd6, 16'h0084));
		emit(encodeI(opSw, 5'd0, 5'd7, 16'h0088));
		emit(encodeI(opSw, 5'd0, 5'd8, 16'h008c));
		emit(encodeI(opSw, 5'd0, 5'd9, 16'h0090));
		emit(encodeR(5'd2, 5'd1, 5'd10, fnSlt));
		emit(encodeI(opLw, 5'd0, 5'd11, 16'h0010));
		// Write to r0, then an opcode the core does not know
		emit(encodeR(5'd1, 5'd2, 5'd0, fnAdd));
		// Both rt and rd fields name r12
		emit(encodeI(6'h08, 5'd1, 5'd12, 16'h6005));
		emit(encodeI(opSw, 5'd0, 5'd10, 16'h0094));
		emit(encodeI(opSw, 5'd0, 5'd11, 16'h0098));
		emit(encodeI(opSw, 5'd0, 5'd0, 16'h009c));
		emit(encodeI(opSw, 5'd0, 5'd12, 16'h00a0));
		// Taken beq skips one store after its three delay slots
		emit(encodeI(opBeq, 5'd1, 5'd1, 16'd4));
		emit(encodeI(opSw, 5'd0, 5'd5, 16'h00a4));
		emit(encodeI(opSw, 5'd0, 5'd6, 16'h00a8));
		emit(encodeI(opSw, 5'd0, 5'd7, 16'h00ac));
		emit(encodeI(opSw, 5'd0, 5'd8, 16'h00b0));
		emit(encodeI(opBeq, 5'd1, 5'd2, 16'd4));
		emit(encodeI(opSw, 5'd0, 5'd9, 16'h00b4));
		emit(encodeI(opSw, 5'd0, 5'd1, 16'h00b8));
		emit(encodeI(opSw, 5'd0, 5'd2, 16'h00bc));
		emit(encodeI(opSw, 5'd0, 5'd3, 16'h00c0));
		emit(encodeI(opSw, 5'd0, 5'd4, 16'h00c4));
	endtask

	// Instruction-level model with three delay slots per taken beq
	task automatic computeExpected();
		wordT r [32];
		wordT m [ramDepth];
		wordT w;
		wordT imm;
		wordT addr;
		wordT val;
		logic [5:0] fn;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		int idx;
		int next;
		int target;
		int slots;
		for (int i = 0; i < 32; i++) begin
			r[5'(i)] = '0;
		end
		for (int i = 0; i < ramDepth; i++) begin
			m[6'(i)] = ramInit[6'(i)];
		end
		idx = 0;
		slots = 0;
		target = 0;
		expCount = 0;
		while (idx < progCount) begin
			w = rom[6'(idx)];
			rs = w[25:21];
			rt = w[20:16];
			rd = w[15:11];
			fn = w[5:0];
			imm = {{16{w[15]}}, w[15:0]};
			addr = r[rs] + imm;
			next = idx + 1;
			// Redirect lands after the third delay slot
			if (slots > 0) begin
				slots--;
				if (slots == 0) begin
					next = target;
				end
			end
			case (w[31:26])
				opRType: begin
					case (fn)
						fnAdd: val = r[rs] + r[rt];
						fnSub: val = r[rs] - r[rt];
						fnAnd: val = r[rs] & r[rt];
						fnOr: val = r[rs] | r[rt];
						fnSlt: val = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
						default: val = '0;
					endcase
					if (rd != '0) begin
						r[rd] = val;
					end
				end
				opLw: begin
					if (rt != '0) begin
						r[rt] = m[addr[7:2]];
					end
				end
				opSw: begin
					expAddr[6'(expCount)] = addr;
					expData[6'(expCount)] = r[rt];
					expCount++;
					m[addr[7:2]] = r[rt];
				end
				opBeq: begin
					brTaken[6'(idx)] = (r[rs] == r[rt]);
					if (r[rs] == r[rt]) begin
						slots = 3;
						target = idx + 1 + int'($signed(w[15:0]));
					end
				end
				default: ;
			endcase
			idx = next;
		end
	endtask

	resetQuiet: assert property (@(posedge clk)
		aroundReset |-> !memRead && !memWrite && instrAddr == resetPc)
		else flagError($sformatf("reset state wrong, instrAddr %h", $sampled(instrAddr)));

	extraStore: assert property (@(posedge clk) disable iff (!rstN)
		memWrite |-> storeIdx < expCount)
		else flagError("store seen beyond the end of the expected list");

	storeMatch: assert property (@(posedge clk) disable iff (!rstN)
		memWrite && storeIdx < expCount |->
			memAddr == expAddr[6'(storeIdx)] && memWData == expData[6'(storeIdx)])
		else flagError($sformatf("store %0d wrote %h to %h, expected %h to %h",
			$sampled(storeIdx), $sampled(memWData), $sampled(memAddr),
			expData[6'($sampled(storeIdx))], expAddr[6'($sampled(storeIdx))]));

	branchFetch: assert property (@(posedge clk) disable iff (!rstN)
		$past(beqFetched, 4) |-> instrAddr == $past(nextFetch, 4))
		else flagError($sformatf("fetch address %h after beq is wrong",
			$sampled(instrAddr)));

	initial begin
		rstN = 1'b0;
		void'($urandom(randomSeed));
		for (int i = 0; i < ramDepth; i++) begin
			ramInit[6'(i)] = $urandom();
		end
		assembleProgram();
		computeExpected();
		endAddr = resetPc + 32'(4 * progCount);
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		wait (instrAddr == endAddr);
		repeat (drainCycles) @(posedge clk);
		leftOver = expCount - storeIdx;
		storesDrained: assert (leftOver == 0)
			else $display("Expected stores never seen: %0d", leftOver);
		$display("Checks done: %0d assertion errors, %0d missing stores", errorCount, leftOver);
		if (errorCount == 0 && leftOver == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: run passed %0d ns before the program end was fetched", watchdogNs);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
